// ==== sim/tb_clock_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Release lands 1 ns after an edge, like the other inputs
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

// ==== sim/tb_pcs_rx_top.sv ====
// PCS receive testbench
`timescale 1ns/1ns

module tb_pcs_rx_top import pcs_rx_pkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    // Cycles per test, four drain cycles included
    localparam int TEST_CYCLES  = 5 + 16 + 9 + 10 + 6 + 100;
    localparam int WDOG_CYCLES  = RESET_CYCLES + 1 + TEST_CYCLES + 100;

    logic                       rx_clk_161_13;
    logic                       async_reset_n;
    logic [1:0]                 lane_rot;
    logic [NUM_LANES-1:0][1:0]  rx_header;
    logic [NUM_LANES-1:0][63:0] rx_data;
    logic                       clear_errblk;
    logic [31:0]                xgmii_rxc;
    logic [255:0]               xgmii_rxd;
    logic [7:0]                 errd_blks;

    // Expected values of the input being driven
    logic [31:0]  cur_rxc;
    logic [255:0] cur_rxd;
    logic [3:0]   cur_err;
    // Delay line, index 1 lines up with the DUT output
    logic [31:0]  exp_rxc [2];
    logic [255:0] exp_rxd [2];
    logic [3:0]   exp_err [2];
    logic [7:0]   exp_cnt;
    block_kind_e  last_kind = KIND_IDLE;
    logic [31:0]  lfsr_state = 32'hc282;
    int           fails = 0;
    int           n_pass = 0;
    int           n_fail = 0;

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clk (
        .clk_o   (rx_clk_161_13),
        .rst_n_o (async_reset_n)
    );

    pcs_rx_top #(
        .ERR_CNT_WIDTH (8)
    ) dut0 (
        .rx_clk_161_13  (rx_clk_161_13),
        .async_reset_n  (async_reset_n),
        .rx_lane_rot_i  (lane_rot),
        .rx_header_i    (rx_header),
        .rx_data_i      (rx_data),
        .clear_errblk_i (clear_errblk),
        .xgmii_rxc_o    (xgmii_rxc),
        .xgmii_rxd_o    (xgmii_rxd),
        .errd_blks_o    (errd_blks)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Random source and block builders
    ////////////////////////////////////////////////////////////////////////////

    // Galois LFSR, one step per bit
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_state[0];
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
        end
        return v;
    endfunction

    function automatic logic [1:0] rand_rot();
        return 2'(take_bits(2));
    endfunction

    function automatic logic [65:0] dat();
        return {SYNC_DATA, take_bits(64)};
    endfunction

    // Control block, random content above the type byte
    function automatic logic [65:0] ctrl(input logic [7:0] btype);
        return {SYNC_CTRL, 56'(take_bits(56)), btype};
    endfunction

    function automatic logic [65:0] idle_blk();
        return ctrl(BT_IDLE);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic void decode_lane(
        input  logic [1:0]  hdr,
        input  logic [63:0] pl,
        input  block_kind_e prev,
        input  logic        term_in,
        output block_kind_e kind,
        output logic [7:0]  c,
        output logic [63:0] d
    );
        kind = KIND_ERROR;
        if (hdr == SYNC_DATA) begin
            kind = KIND_DATA;
            c = 8'h00;
            d = pl;
        end else if (hdr == SYNC_CTRL && pl[7:0] == BT_IDLE) begin
            kind = KIND_IDLE;
            c = 8'hFF;
            d = {8{XG_IDLE}};
        end else if (hdr == SYNC_CTRL && pl[7:0] == BT_START) begin
            kind = KIND_START;
            c = 8'h01;
            d = {pl[63:8], XG_START};
        end else if (hdr == SYNC_CTRL && pl[7:0] == BT_TERM7) begin
            kind = KIND_TERM;
            c = 8'h80;
            d = {XG_TERM, pl[63:8]};
        end else if (hdr == SYNC_CTRL && pl[7:0] == BT_TERM0) begin
            kind = KIND_TERM;
            c = 8'hFF;
            d = {{7{XG_IDLE}}, XG_TERM};
        end
        // Data outside a frame, or non-idle after a terminate
        if (kind == KIND_DATA && (prev == KIND_IDLE || prev == KIND_TERM)) kind = KIND_ERROR;
        if (term_in && kind != KIND_IDLE) kind = KIND_ERROR;
        if (kind == KIND_ERROR) begin
            c = 8'hFF;
            d = {8{XG_ERROR}};
        end
    endfunction

    function automatic logic [7:0] sat_add(input logic [7:0] cnt, input logic [3:0] errs);
        int sum;
        sum = cnt + $countones(errs);
        return (sum > 255) ? 8'hFF : 8'(sum);
    endfunction

    always @(posedge rx_clk_161_13) begin
        exp_rxc[0] <= cur_rxc;
        exp_rxc[1] <= exp_rxc[0];
        exp_rxd[0] <= cur_rxd;
        exp_rxd[1] <= exp_rxd[0];
        exp_err[0] <= cur_err;
        exp_err[1] <= exp_err[0];
        if (!async_reset_n || clear_errblk) begin
            exp_cnt <= '0;
        end else begin
            exp_cnt <= sat_add(exp_cnt, exp_err[1]);
        end
    end

    function automatic void report_mismatch(input string what, input logic [255:0] got,
                                            input logic [255:0] exp);
        $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        fails++;
    endfunction

    assert property (@(posedge rx_clk_161_13) disable iff (!async_reset_n)
                     xgmii_rxc == exp_rxc[1])
        else report_mismatch("xgmii_rxc_o", $sampled(xgmii_rxc), $sampled(exp_rxc[1]));
    assert property (@(posedge rx_clk_161_13) disable iff (!async_reset_n)
                     xgmii_rxd == exp_rxd[1])
        else report_mismatch("xgmii_rxd_o", $sampled(xgmii_rxd), $sampled(exp_rxd[1]));
    assert property (@(posedge rx_clk_161_13) disable iff (!async_reset_n)
                     errd_blks == exp_cnt)
        else report_mismatch("errd_blks_o", $sampled(errd_blks), $sampled(exp_cnt));

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // One cycle of four blocks in logical lane order
    task automatic send(input logic [1:0] r, input logic [65:0] b0, b1, b2, b3);
        logic [3:0][65:0] blks;
        block_kind_e      kind;
        block_kind_e      prev;
        logic             term_seen;
        logic [7:0]       c;
        logic [63:0]      d;
        blks = {b3, b2, b1, b0};
        prev = last_kind;
        term_seen = 1'b0;
        lane_rot = r;
        for (int k = 0; k < NUM_LANES; k++) begin
            // Output lane k is taken from input lane k + rotation
            rx_header[2'(k) + r] = blks[k][65:64];
            rx_data[2'(k) + r]   = blks[k][63:0];
            decode_lane(blks[k][65:64], blks[k][63:0], prev, term_seen, kind, c, d);
            cur_rxc[8*k +: 8]   = c;
            cur_rxd[64*k +: 64] = d;
            cur_err[k] = (kind == KIND_ERROR);
            term_seen = term_seen | (kind == KIND_TERM);
            prev = kind;
        end
        last_kind = prev;
        @(posedge rx_clk_161_13);
        #1;
    endtask

    task automatic end_test(input string name, input int mark);
        repeat (4) send(rand_rot(), idle_blk(), idle_blk(), idle_blk(), idle_blk());
        if (fails == mark) begin
            n_pass++;
            $display("test %s: pass", name);
        end else begin
            n_fail++;
            $display("test %s: fail, %0d errors", name, fails - mark);
        end
    endtask

    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", WDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int mark;
        lane_rot = '0;
        clear_errblk = 1'b0;
        rx_header = {4{SYNC_CTRL}};
        rx_data = {4{{56'd0, BT_IDLE}}};
        cur_rxc = '1;
        cur_rxd = {32{XG_IDLE}};
        cur_err = '0;
        wait (async_reset_n === 1'b1);
        @(posedge rx_clk_161_13);
        #1;

        mark = fails;
        assert (xgmii_rxc == '1 && xgmii_rxd == {32{XG_IDLE}} && errd_blks == '0)
            else report_mismatch("reset state", {xgmii_rxc, errd_blks}, {32'hFFFFFFFF, 8'h0});
        end_test("reset", mark);

        mark = fails;
        for (int r = 0; r < 4; r++) begin
            send(2'(r), ctrl(BT_START), dat(), dat(), dat());
            send(2'(r), dat(), dat(), ctrl(BT_TERM7), idle_blk());
            send(2'(r), idle_blk(), idle_blk(), idle_blk(), idle_blk());
        end
        end_test("frame decode", mark);

        // Terminate in lane 1, then the same with idles behind it
        mark = fails;
        send(rand_rot(), ctrl(BT_START), dat(), dat(), dat());
        send(rand_rot(), dat(), ctrl(BT_TERM7), dat(), dat());
        send(rand_rot(), idle_blk(), idle_blk(), idle_blk(), idle_blk());
        send(rand_rot(), ctrl(BT_START), dat(), dat(), dat());
        send(rand_rot(), dat(), ctrl(BT_TERM7), idle_blk(), idle_blk());
        end_test("terminate chain", mark);

        mark = fails;
        send(rand_rot(), ctrl(BT_START), dat(), dat(), dat());
        send(rand_rot(), dat(), dat(), dat(), ctrl(BT_TERM0));
        send(rand_rot(), dat(), idle_blk(), idle_blk(), idle_blk());
        send(rand_rot(), ctrl(BT_START), dat(), dat(), dat());
        send(rand_rot(), dat(), dat(), dat(), dat());
        send(rand_rot(), dat(), ctrl(BT_TERM7), idle_blk(), idle_blk());
        end_test("cross-cycle sequence", mark);

        mark = fails;
        send(rand_rot(), {2'b00, take_bits(64)}, {2'b11, take_bits(64)}, ctrl(8'h55),
             ctrl(8'h00));
        send(rand_rot(), idle_blk(), idle_blk(), idle_blk(), idle_blk());
        end_test("invalid blocks", mark);

        mark = fails;
        repeat (20) begin
            send(rand_rot(), {2'(take_bits(2)), take_bits(64)}, {2'(take_bits(2)),
                 take_bits(64)}, {2'(take_bits(2)), take_bits(64)},
                 {2'(take_bits(2)), take_bits(64)});
        end
        repeat (2) begin
            send(rand_rot(), {2'b11, take_bits(64)}, {2'b00, take_bits(64)},
                 {2'b11, take_bits(64)}, {2'b00, take_bits(64)});
        end
        // Clear while errors keep arriving
        clear_errblk = 1'b1;
        send(rand_rot(), {2'b00, take_bits(64)}, dat(), dat(), dat());
        clear_errblk = 1'b0;
        repeat (68) begin
            send(rand_rot(), {2'b11, take_bits(64)}, {2'b00, take_bits(64)},
                 {2'b11, take_bits(64)}, {2'b00, take_bits(64)});
        end
        repeat (3) send(rand_rot(), idle_blk(), idle_blk(), idle_blk(), idle_blk());
        assert (errd_blks == 8'hFF)
            else report_mismatch("saturated errd_blks_o", errd_blks, 8'hFF);
        clear_errblk = 1'b1;
        send(rand_rot(), idle_blk(), idle_blk(), idle_blk(), idle_blk());
        clear_errblk = 1'b0;
        send(rand_rot(), idle_blk(), idle_blk(), idle_blk(), idle_blk());
        assert (errd_blks == 8'h00)
            else report_mismatch("cleared errd_blks_o", errd_blks, 8'h00);
        end_test("error counter", mark);

        $display("tests passed %0d, failed %0d, mismatches %0d", n_pass, n_fail, fails);
        if (n_fail == 0 && fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/pcs_rx_pkg.sv
verilog/block_bus_if.sv
verilog/xgmii_bus_if.sv
verilog/rx_lane_reorder.sv
verilog/block_decoder.sv
verilog/rx_lane_bank.sv
verilog/errored_block_counter.sv
verilog/pcs_rx_top.sv
sim/tb_clock_gen.sv
sim/tb_pcs_rx_top.sv

// ==== verilog/block_bus_if.sv ====
// Reordered block bus
`timescale 1ns/1ns

interface block_bus_if import pcs_rx_pkg::*; ();

    // One 66-bit block per lane
    logic [NUM_LANES-1:0][1:0] header;
    block_payload_u [NUM_LANES-1:0] payload;

    modport src (
        output header,
        output payload
    );

    modport dst (
        input  header,
        input  payload
    );

endinterface

// ==== verilog/block_decoder.sv ====
// 64b/66b lane decoder
`timescale 1ns/1ns

module block_decoder import pcs_rx_pkg::*; (
    input  logic           rx_clk_161_13,
    input  logic           async_reset_n,
    input  logic [1:0]     header_i,
    input  block_payload_u payload_i,
    input  block_kind_e    prev_kind_i,
    input  logic           terminate_in_i,
    output block_kind_e    kind_o,
    output logic [7:0]     rxc_o,
    output logic [63:0]    rxd_o,
    output logic           blk_err_o
);

    block_kind_e raw_kind;
    logic [7:0]  raw_rxc;
    logic [63:0] raw_rxd;
    logic        seq_err;

    ////////////////////////////////////////////////////////////////////////////
    // Raw decode from header and block type
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        raw_kind = KIND_ERROR;
        raw_rxc  = 8'hFF;
        raw_rxd  = {8{XG_ERROR}};
        case (header_i)
            SYNC_DATA: begin
                raw_kind = KIND_DATA;
                raw_rxc  = 8'h00;
                raw_rxd  = payload_i.data;
            end
            SYNC_CTRL: begin
                case (payload_i.ctrl.btype)
                    BT_IDLE: begin
                        raw_kind = KIND_IDLE;
                        raw_rxc  = 8'hFF;
                        raw_rxd  = {8{XG_IDLE}};
                    end
                    BT_START: begin
                        raw_kind = KIND_START;
                        raw_rxc  = 8'h01;
                        raw_rxd  = {payload_i.ctrl.content, XG_START};
                    end
                    BT_TERM7: begin
                        // Seven data bytes, terminate last
                        raw_kind = KIND_TERM;
                        raw_rxc  = 8'h80;
                        raw_rxd  = {XG_TERM, payload_i.ctrl.content};
                    end
                    BT_TERM0: begin
                        raw_kind = KIND_TERM;
                        raw_rxc  = 8'hFF;
                        raw_rxd  = {{7{XG_IDLE}}, XG_TERM};
                    end
                    default: begin
                        raw_kind = KIND_ERROR;
                    end
                endcase
            end
            // Headers 00 and 11 are invalid
            default: begin
                raw_kind = KIND_ERROR;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sequence rules
    ////////////////////////////////////////////////////////////////////////////

    // Data outside a frame, or anything but idle after a terminate
    assign seq_err = ((raw_kind == KIND_DATA) &&
                      ((prev_kind_i == KIND_IDLE) || (prev_kind_i == KIND_TERM))) ||
                     (terminate_in_i && (raw_kind != KIND_IDLE));

    always_comb begin
        kind_o = raw_kind;
        if (seq_err) begin
            kind_o = KIND_ERROR;
        end
    end

    always_ff @(posedge rx_clk_161_13) begin
        if (!async_reset_n) begin
            rxc_o     <= 8'hFF;
            rxd_o     <= {8{XG_IDLE}};
            blk_err_o <= 1'b0;
        end else if (kind_o == KIND_ERROR) begin
            rxc_o     <= 8'hFF;
            rxd_o     <= {8{XG_ERROR}};
            blk_err_o <= 1'b1;
        end else begin
            rxc_o     <= raw_rxc;
            rxd_o     <= raw_rxd;
            blk_err_o <= 1'b0;
        end
    end

endmodule

// ==== verilog/errored_block_counter.sv ====
// Errored block counter
`timescale 1ns/1ns

module errored_block_counter import pcs_rx_pkg::*; #(
    parameter int ERR_CNT_WIDTH = 8
) (
    input  logic                     rx_clk_161_13,
    input  logic                     async_reset_n,
    input  logic                     clear_errblk_i,
    xgmii_bus_if.dst                 xg_i,
    output logic [ERR_CNT_WIDTH-1:0] errd_blks_o
);

    localparam int SUM_W = ERR_CNT_WIDTH + 1;

    // Errors this cycle, 0 to 4
    logic [2:0]       n_err;
    logic [SUM_W-1:0] cnt_sum;

    always_comb begin
        n_err = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            n_err = n_err + 3'(xg_i.blk_err[k]);
        end
    end

    // Extra top bit flags overflow
    assign cnt_sum = {1'b0, errd_blks_o} + SUM_W'(n_err);

    always_ff @(posedge rx_clk_161_13) begin
        if (!async_reset_n || clear_errblk_i) begin
            errd_blks_o <= '0;
        end else if (cnt_sum[SUM_W-1]) begin
            errd_blks_o <= '1;
        end else begin
            errd_blks_o <= cnt_sum[ERR_CNT_WIDTH-1:0];
        end
    end

endmodule

// ==== verilog/pcs_rx_pkg.sv ====
// 10G PCS receive definitions
package pcs_rx_pkg;

    localparam int NUM_LANES = 4;

    // Sync headers
    localparam logic [1:0] SYNC_DATA = 2'b01;
    localparam logic [1:0] SYNC_CTRL = 2'b10;

    // Control block type field values
    localparam logic [7:0] BT_IDLE  = 8'h1E;
    localparam logic [7:0] BT_START = 8'h78;
    localparam logic [7:0] BT_TERM7 = 8'hFF;
    localparam logic [7:0] BT_TERM0 = 8'h87;

    // XGMII control characters
    localparam logic [7:0] XG_IDLE  = 8'h07;
    localparam logic [7:0] XG_START = 8'hFB;
    localparam logic [7:0] XG_TERM  = 8'hFD;
    localparam logic [7:0] XG_ERROR = 8'hFE;

    ////////////////////////////////////////////////////////////////////////////
    // Block payload, seen as data or as a control block
    ////////////////////////////////////////////////////////////////////////////

    typedef union packed {
        logic [63:0] data;
        struct packed {
            // Bytes 1 to 7 of the block
            logic [55:0] content;
            // Block type in byte 0
            logic [7:0]  btype;
        } ctrl;
    } block_payload_u;

    // Classification of a decoded block
    typedef enum logic [2:0] {
        KIND_IDLE,
        KIND_DATA,
        KIND_START,
        KIND_TERM,
        KIND_ERROR
    } block_kind_e;

endpackage

// ==== verilog/pcs_rx_top.sv ====
// 10G PCS receive top level
`timescale 1ns/1ns

module pcs_rx_top import pcs_rx_pkg::*; #(
    parameter int ERR_CNT_WIDTH = 8
) (
    input  logic                       rx_clk_161_13,
    input  logic                       async_reset_n,
    input  logic [1:0]                 rx_lane_rot_i,
    input  logic [NUM_LANES-1:0][1:0]  rx_header_i,
    input  logic [NUM_LANES-1:0][63:0] rx_data_i,
    input  logic                       clear_errblk_i,
    output logic [NUM_LANES*8-1:0]     xgmii_rxc_o,
    output logic [NUM_LANES*64-1:0]    xgmii_rxd_o,
    output logic [ERR_CNT_WIDTH-1:0]   errd_blks_o
);

    block_bus_if blk_bus ();
    xgmii_bus_if xg_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // Reorder, decode, count
    ////////////////////////////////////////////////////////////////////////////

    rx_lane_reorder u_reorder (
        .rx_clk_161_13 (rx_clk_161_13),
        .async_reset_n (async_reset_n),
        .rx_lane_rot_i (rx_lane_rot_i),
        .rx_header_i   (rx_header_i),
        .rx_data_i     (rx_data_i),
        .blk_o         (blk_bus)
    );

    rx_lane_bank u_bank (
        .rx_clk_161_13 (rx_clk_161_13),
        .async_reset_n (async_reset_n),
        .blk_i         (blk_bus),
        .xg_o          (xg_bus)
    );

    errored_block_counter #(
        .ERR_CNT_WIDTH (ERR_CNT_WIDTH)
    ) u_err_cnt (
        .rx_clk_161_13  (rx_clk_161_13),
        .async_reset_n  (async_reset_n),
        .clear_errblk_i (clear_errblk_i),
        .xg_i           (xg_bus),
        .errd_blks_o    (errd_blks_o)
    );

    // Flattened XGMII, lane 0 in the low bits
    assign xgmii_rxc_o = xg_bus.rxc;
    assign xgmii_rxd_o = xg_bus.rxd;

endmodule

// ==== verilog/rx_lane_bank.sv ====
// Four-lane decoder bank
`timescale 1ns/1ns

module rx_lane_bank import pcs_rx_pkg::*; (
    input  logic     rx_clk_161_13,
    input  logic     async_reset_n,
    block_bus_if.dst blk_i,
    xgmii_bus_if.src xg_o
);

    block_kind_e lane_kind [NUM_LANES];
    block_kind_e prev_kind [NUM_LANES];
    logic        term_chain [NUM_LANES];
    // Kind of the last lane, seen by lane 0 one cycle later
    block_kind_e last_kind_q;

    always_ff @(posedge rx_clk_161_13) begin
        if (!async_reset_n) begin
            last_kind_q <= KIND_IDLE;
        end else begin
            last_kind_q <= lane_kind[NUM_LANES-1];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Per-lane decode with the prev kind and terminate chains
    ////////////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        if (k == 0) begin : g_first
            assign prev_kind[k]  = last_kind_q;
            assign term_chain[k] = 1'b0;
        end else begin : g_next
            assign prev_kind[k]  = lane_kind[k-1];
            // Any terminate in an earlier lane
            assign term_chain[k] = term_chain[k-1] | (lane_kind[k-1] == KIND_TERM);
        end

        block_decoder u_dec (
            .rx_clk_161_13  (rx_clk_161_13),
            .async_reset_n  (async_reset_n),
            .header_i       (blk_i.header[k]),
            .payload_i      (blk_i.payload[k]),
            .prev_kind_i    (prev_kind[k]),
            .terminate_in_i (term_chain[k]),
            .kind_o         (lane_kind[k]),
            .rxc_o          (xg_o.rxc[k]),
            .rxd_o          (xg_o.rxd[k]),
            .blk_err_o      (xg_o.blk_err[k])
        );
    end

endmodule

// ==== verilog/rx_lane_reorder.sv ====
// Receive lane rotation
`timescale 1ns/1ns

module rx_lane_reorder import pcs_rx_pkg::*; (
    input  logic                       rx_clk_161_13,
    input  logic                       async_reset_n,
    input  logic [1:0]                 rx_lane_rot_i,
    input  logic [NUM_LANES-1:0][1:0]  rx_header_i,
    input  logic [NUM_LANES-1:0][63:0] rx_data_i,
    block_bus_if.src                   blk_o
);

    // Input lane feeding each output lane
    logic [1:0] src_lane [NUM_LANES];

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            // Two-bit sum wraps, giving the mod 4 rotation
            src_lane[k] = 2'(k) + rx_lane_rot_i;
        end
    end

    always_ff @(posedge rx_clk_161_13) begin
        if (!async_reset_n) begin
            // Idle control blocks on every lane
            for (int k = 0; k < NUM_LANES; k++) begin
                blk_o.header[k]  <= SYNC_CTRL;
                blk_o.payload[k] <= {56'd0, BT_IDLE};
            end
        end else begin
            for (int k = 0; k < NUM_LANES; k++) begin
                blk_o.header[k]  <= rx_header_i[src_lane[k]];
                blk_o.payload[k] <= rx_data_i[src_lane[k]];
            end
        end
    end

endmodule

// ==== verilog/xgmii_bus_if.sv ====
// Decoded XGMII lane bus
`timescale 1ns/1ns

interface xgmii_bus_if import pcs_rx_pkg::*; ();

    // Lane 0 sits in the low bits
    logic [NUM_LANES-1:0][7:0]  rxc;
    logic [NUM_LANES-1:0][63:0] rxd;
    logic [NUM_LANES-1:0]       blk_err;

    modport src (
        output rxc,
        output rxd,
        output blk_err
    );

    modport dst (
        input  rxc,
        input  rxd,
        input  blk_err
    );

endinterface
